//--- Makefile
TOP := exu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o exu_sim
	./obj_dir/exu_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
+incdir+include
hdl/exu_pkg.sv
hdl/exu_decoder.sv
hdl/exu_regfile.sv
hdl/exu_alu.sv
hdl/exu_shift_counter.sv
hdl/exu_data_mem.sv
hdl/exu_sequencer.sv
hdl/exu_top.sv
testbench/exu_checker.sv
testbench/exu_tb.sv

//--- hdl/exu_alu.sv
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        step,
  input  exu_op_e     op,
  input  logic [63:0] a,
  input  logic [63:0] b,
  output logic [63:0] result
);

  logic [63:0] sum;
  logic [63:0] calc;

  assign sum = a + b;

  always_comb begin
    case (op)
      OP_SUB:  calc = a - b;
      OP_AND:  calc = a & b;
      OP_OR:   calc = a | b;
      OP_XOR:  calc = a ^ b;
      OP_SLT:  calc = {63'b0, $signed(a) < $signed(b)};
      OP_SLTU: calc = {63'b0, a < b};
      OP_ADDW: calc = {{32{sum[31]}}, sum[31:0]};
      // shift source, stepped later
      OP_SLL, OP_SRL, OP_SRA: calc = a;
      default: calc = sum;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (start) begin
      result <= calc;
    end else if (step) begin
      case (op)
        OP_SLL:  result <= {result[62:0], 1'b0};
        OP_SRA:  result <= {result[63], result[63:1]};
        default: result <= {1'b0, result[63:1]};
      endcase
    end
  end

endmodule

//--- hdl/exu_data_mem.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_data_mem import exu_pkg::*; #(
  parameter int WORDS = `EXU_DMEM_WORDS
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        re,
  input  logic        we,
  input  exu_op_e     op,
  input  logic [63:0] addr,
  input  logic [63:0] wdata,
  output logic [63:0] rdata
);

  localparam int AW = $clog2(WORDS);

  logic [63:0]   mem [WORDS];
  logic [AW-1:0] idx;
  logic [63:0]   word;
  logic [7:0]    mask;
  logic [63:0]   wrep;
  logic [63:0]   load_val;

  assign idx  = addr[AW+2:3];
  assign word = mem[idx];

  // replicate store data so the mask alone picks the lanes
  always_comb begin
    case (op)
      OP_SB: begin
        mask = 8'h01 << addr[2:0];
        wrep = {8{wdata[7:0]}};
      end
      OP_SW: begin
        mask = addr[2] ? 8'hf0 : 8'h0f;
        wrep = {2{wdata[31:0]}};
      end
      OP_SD: begin
        mask = 8'hff;
        wrep = wdata;
      end
      default: begin
        mask = 8'h00;
        wrep = wdata;
      end
    endcase
  end

  always_comb begin
    case (op)
      OP_LBU:  load_val = {56'b0, word[8*addr[2:0] +: 8]};
      OP_LW:   load_val = addr[2] ? {{32{word[63]}}, word[63:32]}
                                  : {{32{word[31]}}, word[31:0]};
      default: load_val = word;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      for (int b = 0; b < 8; b++) begin
        if (mask[b]) mem[idx][8*b +: 8] <= wrep[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= load_val;
    end
  end

endmodule

//--- hdl/exu_decoder.sv
`timescale 1ns/1ps

module exu_decoder import exu_pkg::*; (
  input  logic [31:0]  instr,
  output exu_decoded_t dec
);

  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] imm_u;
  logic [63:0] imm_j;

  assign opc = instr[6:0];
  assign f3  = instr[14:12];
  assign f7  = instr[31:25];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec.op       = OP_ILLEGAL;
    dec.rd       = instr[11:7];
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.imm      = imm_i;
    dec.uses_imm = 1'b1;
    case (opc)
      7'b0110011: begin
        dec.uses_imm = 1'b0;
        if (f7 == 7'b0000000) begin
          case (f3)
            3'b000: dec.op = OP_ADD;
            3'b001: dec.op = OP_SLL;
            3'b010: dec.op = OP_SLT;
            3'b011: dec.op = OP_SLTU;
            3'b100: dec.op = OP_XOR;
            3'b101: dec.op = OP_SRL;
            3'b110: dec.op = OP_OR;
            default: dec.op = OP_AND;
          endcase
        end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
          dec.op = OP_SUB;
        end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
          dec.op = OP_SRA;
        end
      end
      7'b0010011: begin
        case (f3)
          3'b000: dec.op = OP_ADDI;
          3'b100: dec.op = OP_XORI;
          3'b110: dec.op = OP_ORI;
          3'b111: dec.op = OP_ANDI;
          3'b001: if (instr[31:26] == 6'b000000) dec.op = OP_SLLI;
          3'b101: begin
            if (instr[31:26] == 6'b000000) dec.op = OP_SRLI;
            else if (instr[31:26] == 6'b010000) dec.op = OP_SRAI;
          end
          default: dec.op = OP_ILLEGAL;
        endcase
      end
      7'b0111011: begin
        dec.uses_imm = 1'b0;
        if (f7 == 7'b0000000 && f3 == 3'b000) dec.op = OP_ADDW;
      end
      7'b0011011: if (f3 == 3'b000) dec.op = OP_ADDIW;
      7'b0110111: begin
        dec.op  = OP_LUI;
        dec.imm = imm_u;
      end
      7'b0010111: begin
        dec.op  = OP_AUIPC;
        dec.imm = imm_u;
      end
      7'b1101111: begin
        dec.op  = OP_JAL;
        dec.imm = imm_j;
      end
      7'b1100111: if (f3 == 3'b000) dec.op = OP_JALR;
      7'b1100011: begin
        dec.uses_imm = 1'b0;
        dec.imm      = imm_b;
        if (f3 == 3'b000) dec.op = OP_BEQ;
        else if (f3 == 3'b001) dec.op = OP_BNE;
      end
      7'b0000011: begin
        case (f3)
          3'b011: dec.op = OP_LD;
          3'b010: dec.op = OP_LW;
          3'b100: dec.op = OP_LBU;
          default: dec.op = OP_ILLEGAL;
        endcase
      end
      7'b0100011: begin
        dec.imm = imm_s;
        case (f3)
          3'b011: dec.op = OP_SD;
          3'b010: dec.op = OP_SW;
          3'b000: dec.op = OP_SB;
          default: dec.op = OP_ILLEGAL;
        endcase
      end
      7'b1110011: if (instr == 32'h0010_0073) dec.op = OP_EBREAK;
      default: dec.op = OP_ILLEGAL;
    endcase
    // rd field is immediate bits or unused for these
    if (dec.op inside {OP_ILLEGAL, OP_EBREAK, OP_BEQ, OP_BNE, OP_SD, OP_SW, OP_SB}) begin
      dec.rd = 5'd0;
    end
  end

endmodule

//--- hdl/exu_pkg.sv
package exu_pkg;

  typedef enum logic [5:0] {
    OP_ILLEGAL,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_SLTU,
    OP_ADDW,
    OP_ADDI,
    OP_ANDI,
    OP_ORI,
    OP_XORI,
    OP_ADDIW,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLLI,
    OP_SRLI,
    OP_SRAI,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BEQ,
    OP_BNE,
    OP_LD,
    OP_LW,
    OP_LBU,
    OP_SD,
    OP_SW,
    OP_SB,
    OP_EBREAK
  } exu_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXEC,
    ST_SHIFT,
    ST_MEM,
    ST_RETIRE
  } exu_state_e;

  typedef struct packed {
    exu_op_e     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [63:0] imm;
    logic        uses_imm;
  } exu_decoded_t;

  typedef struct packed {
    logic [63:0] pc;
    logic [63:0] next_pc;
    logic [4:0]  rd;
    logic [63:0] wdata;
    logic        we;
    logic        store;
    logic        illegal;
    logic        halt;
  } exu_retire_t;

endpackage

//--- hdl/exu_regfile.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic        we,
  input  logic [4:0]  rd,
  input  logic [63:0] wdata,
  output logic [63:0] rdata1,
  output logic [63:0] rdata2
);

  logic [63:0] regs [`EXU_REG_COUNT];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `EXU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is never written, so it stays zero from reset
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

//--- hdl/exu_sequencer.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_sequencer import exu_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         instr_valid,
  output logic         instr_ready,
  input  logic [31:0]  instr,
  output logic         retire_valid,
  input  logic         retire_ready,
  input  exu_decoded_t dec,
  output logic [31:0]  instr_q,
  output logic [4:0]   rs1,
  output logic [4:0]   rs2,
  input  logic [63:0]  rdata1,
  input  logic [63:0]  rdata2,
  output logic         alu_start,
  output logic         alu_step,
  output exu_op_e      alu_op,
  output logic [63:0]  alu_a,
  output logic [63:0]  alu_b,
  input  logic [63:0]  alu_result,
  output logic         cnt_load,
  output logic [5:0]   cnt_amount,
  input  logic         cnt_busy,
  output logic         mem_re,
  output logic         mem_we,
  output exu_op_e      mem_op,
  output logic [63:0]  mem_addr,
  output logic [63:0]  mem_wdata,
  input  logic [63:0]  mem_rdata,
  output logic         rf_we,
  output logic [4:0]   rf_rd,
  output logic [63:0]  rf_wdata,
  output exu_retire_t  retire
);

  exu_state_e  state_q;
  exu_state_e  state_d;
  logic [63:0] pc;
  logic [63:0] pc_plus4;
  logic        is_shift;
  logic        is_load;
  logic        is_store;
  logic        commit;

  assign pc_plus4 = pc + 64'd4;
  assign is_shift = dec.op inside {OP_SLL, OP_SRL, OP_SRA, OP_SLLI, OP_SRLI, OP_SRAI};
  assign is_load  = dec.op inside {OP_LD, OP_LW, OP_LBU};
  assign is_store = dec.op inside {OP_SD, OP_SW, OP_SB};

  assign instr_ready  = (state_q == ST_IDLE);
  assign retire_valid = (state_q == ST_RETIRE);
  assign commit       = retire_valid && retire_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      pc      <= `EXU_RESET_PC;
      // addi x0, x0, 0 while idle
      instr_q <= 32'h0000_0013;
    end else begin
      state_q <= state_d;
      if (instr_valid && instr_ready) instr_q <= instr;
      if (commit) pc <= retire.next_pc;
    end
  end

  always_comb begin
    state_d   = state_q;
    alu_start = 1'b0;
    alu_step  = 1'b0;
    cnt_load  = 1'b0;
    mem_re    = 1'b0;
    case (state_q)
      ST_IDLE: if (instr_valid) state_d = ST_EXEC;
      ST_EXEC: begin
        alu_start = 1'b1;
        if (is_shift) begin
          cnt_load = 1'b1;
          state_d  = ST_SHIFT;
        end else if (is_load) begin
          state_d = ST_MEM;
        end else begin
          state_d = ST_RETIRE;
        end
      end
      ST_SHIFT: begin
        alu_step = cnt_busy;
        if (!cnt_busy) state_d = ST_RETIRE;
      end
      ST_MEM: begin
        mem_re  = 1'b1;
        state_d = ST_RETIRE;
      end
      ST_RETIRE: if (retire_ready) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // immediate forms share the register-form datapath
  always_comb begin
    case (dec.op)
      OP_ADDI:  alu_op = OP_ADD;
      OP_ANDI:  alu_op = OP_AND;
      OP_ORI:   alu_op = OP_OR;
      OP_XORI:  alu_op = OP_XOR;
      OP_ADDIW: alu_op = OP_ADDW;
      OP_SLLI:  alu_op = OP_SLL;
      OP_SRLI:  alu_op = OP_SRL;
      OP_SRAI:  alu_op = OP_SRA;
      OP_BEQ, OP_BNE: alu_op = OP_SUB;
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_ADDW,
      OP_SLL, OP_SRL, OP_SRA: alu_op = dec.op;
      default: alu_op = OP_ADD;
    endcase
  end

  assign rs1        = dec.rs1;
  assign rs2        = dec.rs2;
  assign alu_a      = (dec.op inside {OP_AUIPC, OP_JAL}) ? pc : rdata1;
  assign alu_b      = dec.uses_imm ? dec.imm : rdata2;
  assign cnt_amount = dec.uses_imm ? dec.imm[5:0] : rdata2[5:0];

  assign mem_op    = dec.op;
  assign mem_addr  = alu_result;
  assign mem_wdata = rdata2;
  assign mem_we    = commit && is_store;

  always_comb begin
    retire.pc      = pc;
    retire.next_pc = pc_plus4;
    retire.wdata   = alu_result;
    case (dec.op)
      OP_JAL:     retire.next_pc = alu_result;
      OP_JALR:    retire.next_pc = {alu_result[63:1], 1'b0};
      OP_BEQ:     if (alu_result == 64'd0) retire.next_pc = pc + dec.imm;
      OP_BNE:     if (alu_result != 64'd0) retire.next_pc = pc + dec.imm;
      // illegal word leaves the pc where it is
      OP_ILLEGAL: retire.next_pc = pc;
      default:    retire.next_pc = pc_plus4;
    endcase
    if (dec.op == OP_LUI) retire.wdata = dec.imm;
    else if (dec.op inside {OP_JAL, OP_JALR}) retire.wdata = pc_plus4;
    else if (is_load) retire.wdata = mem_rdata;
    retire.rd      = dec.rd;
    retire.we      = (dec.rd != 5'd0);
    retire.store   = is_store;
    retire.illegal = (dec.op == OP_ILLEGAL);
    retire.halt    = (dec.op == OP_EBREAK);
  end

  assign rf_we    = commit && retire.we;
  assign rf_rd    = retire.rd;
  assign rf_wdata = retire.wdata;

endmodule

//--- hdl/exu_shift_counter.sv
`timescale 1ns/1ps

module exu_shift_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [5:0] amount,
  output logic       busy
);

  logic [5:0] count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= amount;
    end else if (count != 6'd0) begin
      count <= count - 6'd1;
    end
  end

  // one shift step per busy cycle
  assign busy = (count != 6'd0);

endmodule

//--- hdl/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  output logic        instr_ready,
  input  logic [31:0] instr,
  output logic        retire_valid,
  input  logic        retire_ready,
  output exu_retire_t retire
);

  exu_decoded_t dec;
  logic [31:0]  instr_q;
  logic [4:0]   rs1;
  logic [4:0]   rs2;
  logic [63:0]  rdata1;
  logic [63:0]  rdata2;
  logic         alu_start;
  logic         alu_step;
  exu_op_e      alu_op;
  logic [63:0]  alu_a;
  logic [63:0]  alu_b;
  logic [63:0]  alu_result;
  logic         cnt_load;
  logic [5:0]   cnt_amount;
  logic         cnt_busy;
  logic         mem_re;
  logic         mem_we;
  exu_op_e      mem_op;
  logic [63:0]  mem_addr;
  logic [63:0]  mem_wdata;
  logic [63:0]  mem_rdata;
  logic         rf_we;
  logic [4:0]   rf_rd;
  logic [63:0]  rf_wdata;

  exu_decoder i_decoder (
    .instr (instr_q),
    .dec   (dec)
  );

  exu_sequencer i_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .dec          (dec),
    .instr_q      (instr_q),
    .rs1          (rs1),
    .rs2          (rs2),
    .rdata1       (rdata1),
    .rdata2       (rdata2),
    .alu_start    (alu_start),
    .alu_step     (alu_step),
    .alu_op       (alu_op),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_result   (alu_result),
    .cnt_load     (cnt_load),
    .cnt_amount   (cnt_amount),
    .cnt_busy     (cnt_busy),
    .mem_re       (mem_re),
    .mem_we       (mem_we),
    .mem_op       (mem_op),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .rf_we        (rf_we),
    .rf_rd        (rf_rd),
    .rf_wdata     (rf_wdata),
    .retire       (retire)
  );

  exu_shift_counter i_shift_counter (
    .clk    (clk),
    .rst_n  (rst_n),
    .load   (cnt_load),
    .amount (cnt_amount),
    .busy   (cnt_busy)
  );

  exu_regfile i_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1    (rs1),
    .rs2    (rs2),
    .we     (rf_we),
    .rd     (rf_rd),
    .wdata  (rf_wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  exu_alu i_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (alu_start),
    .step   (alu_step),
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  exu_data_mem i_data_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .re    (mem_re),
    .we    (mem_we),
    .op    (mem_op),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

//--- include/exu_config.svh
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// architectural integer registers
`define EXU_REG_COUNT 32

// data memory depth in 64-bit words indexed by addr[8:3]
`define EXU_DMEM_WORDS 64

`define EXU_RESET_PC 64'h0000_0000_8000_0000

`endif

//--- testbench/exu_checker.sv
`timescale 1ns/1ps

module exu_checker import exu_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        instr_ready,
  input logic        retire_valid,
  input logic        retire_ready,
  input exu_retire_t retire
);

  // record held while the consumer stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire))
    else $error("retire record changed while stalled");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(instr_ready && retire_valid))
    else $error("instr_ready and retire_valid high together");

  assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> !(retire.we && retire.rd == 5'd0))
    else $error("write enable set for x0");

  // first edge out of reset
  assert property (@(posedge clk)
    $rose(rst_n) |-> instr_ready && !retire_valid)
    else $error("handshake outputs not idle after reset");

endmodule

bind exu_top exu_checker i_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .instr_ready  (instr_ready),
  .retire_valid (retire_valid),
  .retire_ready (retire_ready),
  .retire       (retire)
);

//--- testbench/exu_tb.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb import exu_pkg::*; ();

  localparam int WAIT_LIMIT = 200;
  localparam int NUM_INSTR  = 2000;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] instr;
  logic        retire_valid;
  logic        retire_ready;
  exu_retire_t retire;

  int          seed;
  int          errors;
  int          timeouts;

  // reference model state
  logic [63:0] mregs [32];
  logic [63:0] mmem [64];
  logic [63:0] mpc;

  // instruction being built and run
  exu_op_e     cur_op;
  logic [4:0]  cur_rd;
  logic [4:0]  cur_rs1;
  logic [4:0]  cur_rs2;
  logic [63:0] cur_imm;
  logic [31:0] cur_word;

  exu_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {f7, cur_rs2, cur_rs1, f3, cur_rd, opc};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] i12, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {i12, cur_rs1, f3, cur_rd, opc};
  endfunction

  task automatic build_instr();
    logic [31:0] r;
    logic [31:0] s;
    logic [11:0] i12;
    logic [12:0] b13;
    logic [19:0] u20;
    logic [20:0] j21;
    logic [5:0]  sh;
    r = $random(seed);
    s = $random(seed);
    cur_op  = exu_op_e'(r[5:0] % 6'd33);
    cur_rd  = {2'b00, r[8:6]};
    cur_rs1 = {2'b00, r[11:9]};
    cur_rs2 = {2'b00, r[14:12]};
    i12 = s[11:0];
    sh  = s[17:12];
    // memory ops mostly use x0 plus a small aligned offset
    if (cur_op inside {OP_LD, OP_LW, OP_LBU, OP_SD, OP_SW, OP_SB}) begin
      if (r[17:16] != 2'b00) begin
        cur_rs1 = 5'd0;
        i12 = {3'b000, s[8:0]};
      end
      if (cur_op inside {OP_LD, OP_SD}) i12[2:0] = 3'b000;
      if (cur_op inside {OP_LW, OP_SW}) i12[1:0] = 2'b00;
    end
    cur_imm = {{52{i12[11]}}, i12};
    case (cur_op)
      OP_ADD:   cur_word = rtype(7'h00, 3'd0, 7'b0110011);
      OP_SUB:   cur_word = rtype(7'h20, 3'd0, 7'b0110011);
      OP_SLL:   cur_word = rtype(7'h00, 3'd1, 7'b0110011);
      OP_SLT:   cur_word = rtype(7'h00, 3'd2, 7'b0110011);
      OP_SLTU:  cur_word = rtype(7'h00, 3'd3, 7'b0110011);
      OP_XOR:   cur_word = rtype(7'h00, 3'd4, 7'b0110011);
      OP_SRL:   cur_word = rtype(7'h00, 3'd5, 7'b0110011);
      OP_SRA:   cur_word = rtype(7'h20, 3'd5, 7'b0110011);
      OP_OR:    cur_word = rtype(7'h00, 3'd6, 7'b0110011);
      OP_AND:   cur_word = rtype(7'h00, 3'd7, 7'b0110011);
      OP_ADDW:  cur_word = rtype(7'h00, 3'd0, 7'b0111011);
      OP_ADDI:  cur_word = itype(i12, 3'd0, 7'b0010011);
      OP_XORI:  cur_word = itype(i12, 3'd4, 7'b0010011);
      OP_ORI:   cur_word = itype(i12, 3'd6, 7'b0010011);
      OP_ANDI:  cur_word = itype(i12, 3'd7, 7'b0010011);
      OP_ADDIW: cur_word = itype(i12, 3'd0, 7'b0011011);
      OP_JALR:  cur_word = itype(i12, 3'd0, 7'b1100111);
      OP_LD:    cur_word = itype(i12, 3'd3, 7'b0000011);
      OP_LW:    cur_word = itype(i12, 3'd2, 7'b0000011);
      OP_LBU:   cur_word = itype(i12, 3'd4, 7'b0000011);
      OP_SLLI, OP_SRLI, OP_SRAI: begin
        cur_imm = {58'd0, sh};
        if (cur_op == OP_SLLI) cur_word = itype({6'b000000, sh}, 3'd1, 7'b0010011);
        else if (cur_op == OP_SRLI) cur_word = itype({6'b000000, sh}, 3'd5, 7'b0010011);
        else cur_word = itype({6'b010000, sh}, 3'd5, 7'b0010011);
      end
      OP_LUI, OP_AUIPC: begin
        u20 = s[31:12];
        cur_imm  = {{32{u20[19]}}, u20, 12'd0};
        cur_word = {u20, cur_rd, (cur_op == OP_LUI) ? 7'b0110111 : 7'b0010111};
      end
      OP_JAL: begin
        j21 = {s[20:1], 1'b0};
        cur_imm  = {{43{j21[20]}}, j21};
        cur_word = {j21[20], j21[10:1], j21[11], j21[19:12], cur_rd, 7'b1101111};
      end
      OP_BEQ, OP_BNE: begin
        // equal operands now and then so branches are taken
        if (r[15]) cur_rs2 = cur_rs1;
        b13 = {s[12:1], 1'b0};
        cur_imm  = {{51{b13[12]}}, b13};
        cur_rd   = 5'd0;
        cur_word = {b13[12], b13[10:5], cur_rs2, cur_rs1, (cur_op == OP_BEQ) ? 3'd0 : 3'd1,
                    b13[4:1], b13[11], 7'b1100011};
      end
      OP_SD, OP_SW, OP_SB: begin
        cur_rd   = 5'd0;
        cur_word = {i12[11:5], cur_rs2, cur_rs1,
                    (cur_op == OP_SD) ? 3'd3 : ((cur_op == OP_SW) ? 3'd2 : 3'd0),
                    i12[4:0], 7'b0100011};
      end
      OP_EBREAK: begin
        cur_rd   = 5'd0;
        cur_word = 32'h0010_0073;
      end
      default: begin
        // mul, all-zero word, ecall and lh are outside the subset
        case (s[31:30])
          2'd0:    cur_word = rtype(7'h01, 3'd0, 7'b0110011);
          2'd1:    cur_word = 32'h0000_0000;
          2'd2:    cur_word = 32'h0000_0073;
          default: cur_word = itype(i12, 3'd1, 7'b0000011);
        endcase
        cur_op = OP_ILLEGAL;
        cur_rd = 5'd0;
      end
    endcase
  endtask

  function automatic exu_retire_t predict();
    exu_retire_t e;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] addr;
    logic [63:0] w;
    logic [63:0] t;
    a    = mregs[cur_rs1];
    b    = mregs[cur_rs2];
    res  = '0;
    addr = a + cur_imm;
    w    = mmem[addr[8:3]];
    e    = '0;
    e.pc      = mpc;
    e.next_pc = mpc + 64'd4;
    e.rd      = cur_rd;
    e.we      = (cur_rd != 5'd0);
    case (cur_op)
      OP_ADD:   res = a + b;
      OP_SUB:   res = a - b;
      OP_AND:   res = a & b;
      OP_OR:    res = a | b;
      OP_XOR:   res = a ^ b;
      OP_SLT:   res = {63'd0, $signed(a) < $signed(b)};
      OP_SLTU:  res = {63'd0, a < b};
      OP_ADDW: begin
        t   = a + b;
        res = {{32{t[31]}}, t[31:0]};
      end
      OP_ADDI:  res = a + cur_imm;
      OP_ANDI:  res = a & cur_imm;
      OP_ORI:   res = a | cur_imm;
      OP_XORI:  res = a ^ cur_imm;
      OP_ADDIW: begin
        t   = a + cur_imm;
        res = {{32{t[31]}}, t[31:0]};
      end
      OP_SLL:   res = a << b[5:0];
      OP_SRL:   res = a >> b[5:0];
      OP_SRA:   res = $signed(a) >>> b[5:0];
      OP_SLLI:  res = a << cur_imm[5:0];
      OP_SRLI:  res = a >> cur_imm[5:0];
      OP_SRAI:  res = $signed(a) >>> cur_imm[5:0];
      OP_LUI:   res = cur_imm;
      OP_AUIPC: res = mpc + cur_imm;
      OP_JAL: begin
        res       = mpc + 64'd4;
        e.next_pc = mpc + cur_imm;
      end
      OP_JALR: begin
        res       = mpc + 64'd4;
        e.next_pc = {addr[63:1], 1'b0};
      end
      OP_BEQ:   if (a == b) e.next_pc = mpc + cur_imm;
      OP_BNE:   if (a != b) e.next_pc = mpc + cur_imm;
      OP_LD:    res = w;
      OP_LW:    res = addr[2] ? {{32{w[63]}}, w[63:32]} : {{32{w[31]}}, w[31:0]};
      OP_LBU:   res = {56'd0, w[8*addr[2:0] +: 8]};
      OP_SD, OP_SW, OP_SB: e.store = 1'b1;
      OP_EBREAK: e.halt = 1'b1;
      default: begin
        e.illegal = 1'b1;
        e.next_pc = mpc;
      end
    endcase
    e.wdata = res;
    return e;
  endfunction

  task automatic commit_model(input exu_retire_t e);
    logic [63:0] addr;
    logic [63:0] b;
    addr = mregs[cur_rs1] + cur_imm;
    b    = mregs[cur_rs2];
    case (cur_op)
      OP_SD: mmem[addr[8:3]] = b;
      OP_SW: begin
        if (addr[2]) mmem[addr[8:3]][63:32] = b[31:0];
        else mmem[addr[8:3]][31:0] = b[31:0];
      end
      OP_SB: mmem[addr[8:3]][8*addr[2:0] +: 8] = b[7:0];
      default: ;
    endcase
    if (e.we) mregs[e.rd] = e.wdata;
    mpc = e.next_pc;
  endtask

  task automatic compare_reg(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_retire(input exu_retire_t got, input exu_retire_t exp);
    compare_reg("retire.pc", got.pc, exp.pc);
    compare_reg("retire.next_pc", got.next_pc, exp.next_pc);
    // wdata only matters when a register is written
    if (exp.we) compare_reg("retire.wdata", got.wdata, exp.wdata);
    if (got.rd !== exp.rd) begin
      $display("mismatch at %0t: retire.rd got %0d expected %0d", $time, got.rd, exp.rd);
      errors++;
    end
    if (got.we !== exp.we) begin
      $display("mismatch at %0t: retire.we got %b expected %b", $time, got.we, exp.we);
      errors++;
    end
    if (got.store !== exp.store) begin
      $display("mismatch at %0t: retire.store got %b expected %b", $time, got.store,
               exp.store);
      errors++;
    end
    if (got.illegal !== exp.illegal) begin
      $display("mismatch at %0t: retire.illegal got %b expected %b", $time, got.illegal,
               exp.illegal);
      errors++;
    end
    if (got.halt !== exp.halt) begin
      $display("mismatch at %0t: retire.halt got %b expected %b", $time, got.halt, exp.halt);
      errors++;
    end
  endtask

  // called and returns one ns after a rising edge
  task automatic send_instr();
    int cycles;
    cycles      = 0;
    instr       = cur_word;
    instr_valid = 1'b1;
    while (!instr_ready && timeouts == 0) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout at %0t: instr_ready stayed low for %0d cycles", $time, cycles);
        timeouts++;
      end
    end
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic collect_retire(output exu_retire_t got);
    int          cycles;
    logic        done;
    logic [31:0] r;
    cycles = 0;
    done   = 1'b0;
    got    = '0;
    while (!done && timeouts == 0) begin
      r = $random(seed);
      retire_ready = (r[1:0] != 2'b00);
      if (retire_valid && retire_ready) begin
        got  = retire;
        done = 1'b1;
      end
      @(posedge clk);
      #1;
      cycles++;
      if (!done && cycles > WAIT_LIMIT) begin
        $display("timeout at %0t: no retire record within %0d cycles", $time, cycles);
        timeouts++;
      end
    end
    retire_ready = 1'b0;
  endtask

  task automatic run_one(output exu_retire_t got);
    exu_retire_t exp;
    exp = predict();
    send_instr();
    collect_retire(got);
    if (timeouts == 0) begin
      compare_retire(got, exp);
      commit_model(exp);
    end
  endtask

  // or xk, xk, x0 returns xk unchanged in wdata
  task automatic read_back_regs();
    exu_retire_t got;
    for (int k = 0; k < 8; k++) begin
      cur_op   = OP_OR;
      cur_rd   = 5'(k);
      cur_rs1  = 5'(k);
      cur_rs2  = 5'd0;
      cur_imm  = '0;
      cur_word = {7'd0, 5'd0, cur_rs1, 3'b110, cur_rd, 7'b0110011};
      run_one(got);
      if (timeouts == 0) compare_reg($sformatf("x%0d", k), got.wdata, mregs[k]);
    end
  endtask

  initial begin
    exu_retire_t got;
    logic [31:0] r;
    seed         = 75588;
    errors       = 0;
    timeouts     = 0;
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b0;
    mpc          = `EXU_RESET_PC;
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    for (int i = 0; i < 64; i++) mmem[i] = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int n = 0; n < NUM_INSTR && timeouts == 0; n++) begin
      build_instr();
      run_one(got);
      if (n % 200 == 199) read_back_regs();
      r = $random(seed);
      if (r[2:0] == 3'd0) begin
        @(posedge clk);
        #1;
      end
    end
    $display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
